/* source/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // RV32I major opcodes used by the back end
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // Same encoding as funct3 of loads and stores, bit 2 is the unsigned flag
    typedef enum logic [2:0] {
        mem_byte   = 3'b000,
        mem_half   = 3'b001,
        mem_word   = 3'b010,
        mem_byte_u = 3'b100,
        mem_half_u = 3'b101
    } mem_size_e;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

`default_nettype wire

/* source/stage_if.sv */
`default_nettype none

// ID/EX pipeline register contents
interface id_ex_if;
    import backend_pkg::*;

    word_t     pc;
    word_t     rs1_value;
    word_t     rs2_value;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    alu_op_e   alu_op;
    logic      a_is_pc;
    logic      b_is_imm;
    logic      branch;
    logic [2:0] funct3;
    logic      jal;
    logic      jalr;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      reg_write;

    modport decode (
        output pc, rs1_value, rs2_value, rs1, rs2, rd, imm, alu_op, a_is_pc, b_is_imm,
               branch, funct3, jal, jalr, mem_read, mem_write, mem_size, reg_write
    );

    modport execute (
        input pc, rs1_value, rs2_value, rs1, rs2, rd, imm, alu_op, a_is_pc, b_is_imm,
              branch, funct3, jal, jalr, mem_read, mem_write, mem_size, reg_write
    );
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if;
    import backend_pkg::*;

    word_t     result;
    word_t     store_data;
    reg_idx_t  rd;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;

    modport execute (
        output result, store_data, rd, reg_write, mem_read, mem_write, mem_size
    );

    modport memory (
        input result, store_data, rd, reg_write, mem_read, mem_write, mem_size
    );
endinterface

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  backend_pkg::reg_idx_t rs1,
    input  backend_pkg::reg_idx_t rs2,
    output backend_pkg::word_t    rs1_value,
    output backend_pkg::word_t    rs2_value,
    input  backend_pkg::reg_idx_t wb_rd,
    input  logic                  wb_write,
    input  backend_pkg::word_t    wb_data
);
    import backend_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];
    logic            write_en;

    assign write_en = wb_write && (wb_rd != '0);

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (write_en && (idx == wb_rd))
            return wb_data;
        return regs[idx];
    endfunction

    always_comb begin
        rs1_value = read_port(rs1);
        rs2_value = read_port(rs2);
    end

    // No writes while in reset
    always_ff @(posedge clk) begin
        if (rst_n && write_en)
            regs[wb_rd] <= wb_data;
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`default_nettype none

module decode_stage #(
    parameter backend_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instruction_valid,
    input  backend_pkg::word_t    pc_in,
    input  backend_pkg::word_t    instruction,
    output backend_pkg::reg_idx_t rs1,
    output backend_pkg::reg_idx_t rs2,
    input  backend_pkg::word_t    rs1_value,
    input  backend_pkg::word_t    rs2_value,
    input  logic                  hold,
    input  logic                  redirect,
    output logic                  load_use_stall,
    id_ex_if.decode               id_ex
);
    import backend_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;
    alu_op_e    alu_op;
    logic       a_is_pc;
    logic       b_is_imm;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       bubble;

    function automatic alu_op_e alu_from_funct(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // ==================================================
    // Field split and immediates
    // ==================================================
    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    // LUI reads x0 so the ALU adds the immediate to zero
    assign rs1    = (opcode == op_lui) ? '0 : instruction[19:15];
    assign rs2    = instruction[24:20];

    assign imm_i = {{(xlen-12){instruction[31]}}, instruction[31:20]};
    assign imm_s = {{(xlen-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{(xlen-13){instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{(xlen-21){instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // Control
    always_comb begin
        alu_op    = alu_add;
        imm       = imm_i;
        a_is_pc   = 1'b0;
        b_is_imm  = 1'b1;
        branch    = 1'b0;
        jal       = 1'b0;
        jalr      = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op    = alu_from_funct(funct3, instruction[30]);
                b_is_imm  = 1'b0;
                reg_write = 1'b1;
            end
            op_imm: begin
                // Bit 30 is part of the immediate except for shifts
                alu_op    = alu_from_funct(funct3, (funct3 == 3'b101) && instruction[30]);
                reg_write = 1'b1;
            end
            op_load: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            op_store: begin
                imm       = imm_s;
                mem_write = 1'b1;
            end
            op_branch: begin
                imm      = imm_b;
                b_is_imm = 1'b0;
                branch   = 1'b1;
            end
            op_jal: begin
                imm       = imm_j;
                jal       = 1'b1;
                reg_write = 1'b1;
            end
            op_jalr: begin
                jalr      = 1'b1;
                reg_write = 1'b1;
            end
            op_lui: begin
                imm       = imm_u;
                reg_write = 1'b1;
            end
            op_auipc: begin
                imm       = imm_u;
                a_is_pc   = 1'b1;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // ==================================================
    // Load-use hazard and ID/EX register
    // ==================================================
    assign load_use_stall = instruction_valid && id_ex.mem_read && (id_ex.rd != '0)
                            && ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    assign bubble = redirect || load_use_stall || !instruction_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.pc        <= reset_pc;
            id_ex.branch    <= 1'b0;
            id_ex.jal       <= 1'b0;
            id_ex.jalr      <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
        end else if (!hold) begin
            id_ex.pc        <= bubble ? reset_pc : pc_in;
            id_ex.branch    <= branch && !bubble;
            id_ex.jal       <= jal && !bubble;
            id_ex.jalr      <= jalr && !bubble;
            id_ex.mem_read  <= mem_read && !bubble;
            id_ex.mem_write <= mem_write && !bubble;
            id_ex.reg_write <= reg_write && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            id_ex.rs1_value <= rs1_value;
            id_ex.rs2_value <= rs2_value;
            id_ex.rs1       <= rs1;
            id_ex.rs2       <= rs2;
            id_ex.rd        <= instruction[11:7];
            id_ex.imm       <= imm;
            id_ex.alu_op    <= alu_op;
            id_ex.a_is_pc   <= a_is_pc;
            id_ex.b_is_imm  <= b_is_imm;
            id_ex.funct3    <= funct3;
            id_ex.mem_size  <= mem_size_e'(funct3);
        end
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold,
    id_ex_if.execute              id_ex,
    ex_mem_if.execute             ex_mem,
    input  backend_pkg::reg_idx_t wb_rd,
    input  logic                  wb_write,
    input  backend_pkg::word_t    wb_data,
    output logic                  redirect,
    output backend_pkg::word_t    redirect_pc
);
    import backend_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;
    word_t              rs1_fwd;
    word_t              rs2_fwd;
    word_t              op_a;
    word_t              op_b;
    word_t              alu_out;
    logic [shamt_w-1:0] shamt;
    logic               cond;

    // Newest producer wins, x0 never forwards
    function automatic fwd_sel_e fwd_select(reg_idx_t rs);
        if (ex_mem.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == rs))
            return fwd_mem;
        if (wb_write && (wb_rd != '0) && (wb_rd == rs))
            return fwd_wb;
        return fwd_reg;
    endfunction

    function automatic word_t fwd_value(fwd_sel_e sel, word_t reg_value);
        case (sel)
            fwd_mem: return ex_mem.result;
            fwd_wb:  return wb_data;
            default: return reg_value;
        endcase
    endfunction

    // ==================================================
    // Operands and ALU
    // ==================================================
    always_comb begin
        fwd_a   = fwd_select(id_ex.rs1);
        fwd_b   = fwd_select(id_ex.rs2);
        rs1_fwd = fwd_value(fwd_a, id_ex.rs1_value);
        rs2_fwd = fwd_value(fwd_b, id_ex.rs2_value);
    end

    assign op_a  = id_ex.a_is_pc ? id_ex.pc : rs1_fwd;
    assign op_b  = id_ex.b_is_imm ? id_ex.imm : rs2_fwd;
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (id_ex.alu_op)
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $signed(op_a) >>> shamt;
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // ==================================================
    // Branch and jump resolution
    // ==================================================
    always_comb begin
        case (id_ex.funct3)
            3'b000:  cond = rs1_fwd == rs2_fwd;
            3'b001:  cond = rs1_fwd != rs2_fwd;
            3'b100:  cond = $signed(rs1_fwd) < $signed(rs2_fwd);
            3'b101:  cond = $signed(rs1_fwd) >= $signed(rs2_fwd);
            3'b110:  cond = rs1_fwd < rs2_fwd;
            3'b111:  cond = rs1_fwd >= rs2_fwd;
            default: cond = 1'b0;
        endcase
    end

    // Front end always predicts not taken
    assign redirect    = id_ex.jal || id_ex.jalr || (id_ex.branch && cond);
    assign redirect_pc = id_ex.jalr ? ((rs1_fwd + id_ex.imm) & ~word_t'(1))
                                    : (id_ex.pc + id_ex.imm);

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else if (!hold) begin
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            // Jumps link PC+4
            ex_mem.result     <= (id_ex.jal || id_ex.jalr) ? id_ex.pc + word_t'(4) : alu_out;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_size   <= id_ex.mem_size;
        end
    end

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`default_nettype none

module memory_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                hold,
    ex_mem_if.memory                            ex_mem,
    output backend_pkg::word_t                  mem_address,
    output backend_pkg::word_t                  mem_write_data,
    output logic [backend_pkg::xlen/8-1:0]      mem_byte_enable,
    output logic                                mem_write,
    output logic                                mem_read,
    input  backend_pkg::word_t                  mem_read_data,
    output backend_pkg::reg_idx_t               wb_rd,
    output logic                                wb_write,
    output backend_pkg::word_t                  wb_data
);
    import backend_pkg::*;

    localparam int lanes = xlen / 8;

    logic [1:0] lane;
    word_t      shifted;
    word_t      load_data;
    word_t      wb_load;
    word_t      wb_result;
    logic       wb_is_load;

    assign mem_address = ex_mem.result;
    assign mem_write   = ex_mem.mem_write;
    assign mem_read    = ex_mem.mem_read;
    assign lane        = ex_mem.result[1:0];

    // Store data copied into every lane, enables pick the addressed ones
    always_comb begin
        case (ex_mem.mem_size)
            mem_byte, mem_byte_u: begin
                mem_write_data  = {lanes{ex_mem.store_data[7:0]}};
                mem_byte_enable = {{(lanes-1){1'b0}}, 1'b1} << lane;
            end
            mem_half, mem_half_u: begin
                mem_write_data  = {(lanes/2){ex_mem.store_data[15:0]}};
                mem_byte_enable = {{(lanes-2){1'b0}}, 2'b11} << {lane[1], 1'b0};
            end
            default: begin
                mem_write_data  = ex_mem.store_data;
                mem_byte_enable = '1;
            end
        endcase
    end

    // Load alignment and extension
    assign shifted = mem_read_data >> {lane, 3'b000};

    always_comb begin
        case (ex_mem.mem_size)
            mem_byte:   load_data = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            mem_byte_u: load_data = {{(xlen-8){1'b0}}, shifted[7:0]};
            mem_half:   load_data = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            mem_half_u: load_data = {{(xlen-16){1'b0}}, shifted[15:0]};
            default:    load_data = mem_read_data;
        endcase
    end

    // ==================================================
    // MEM/WB register and writeback select
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_write <= 1'b0;
        else if (!hold)
            wb_write <= ex_mem.reg_write;
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_rd      <= ex_mem.rd;
            wb_load    <= load_data;
            wb_result  <= ex_mem.result;
            wb_is_load <= ex_mem.mem_read;
        end
    end

    assign wb_data = wb_is_load ? wb_load : wb_result;

endmodule

`default_nettype wire

/* source/backend.sv */
`default_nettype none

module backend #(
    parameter backend_pkg::word_t reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instruction_valid,
    input  backend_pkg::word_t             pc_in,
    input  backend_pkg::word_t             instruction,
    output backend_pkg::word_t             mem_address,
    output backend_pkg::word_t             mem_write_data,
    output logic [backend_pkg::xlen/8-1:0] mem_byte_enable,
    output logic                           mem_write,
    output logic                           mem_read,
    input  backend_pkg::word_t             mem_read_data,
    input  logic                           mem_busy,
    output logic                           stall,
    output logic                           redirect,
    output backend_pkg::word_t             redirect_pc
);
    import backend_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_value;
    word_t    rs2_value;
    reg_idx_t wb_rd;
    logic     wb_write;
    word_t    wb_data;
    logic     load_use_stall;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    // Busy memory freezes the whole pipe, load-use only the front
    assign stall = load_use_stall || mem_busy;

    register_file i_register_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb_rd     (wb_rd),
        .wb_write  (wb_write),
        .wb_data   (wb_data)
    );

    decode_stage #(
        .reset_pc (reset_pc)
    ) i_decode_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .instruction_valid (instruction_valid),
        .pc_in             (pc_in),
        .instruction       (instruction),
        .rs1               (rs1),
        .rs2               (rs2),
        .rs1_value         (rs1_value),
        .rs2_value         (rs2_value),
        .hold              (mem_busy),
        .redirect          (redirect),
        .load_use_stall    (load_use_stall),
        .id_ex             (id_ex.decode)
    );

    execute_stage i_execute_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (mem_busy),
        .id_ex       (id_ex.execute),
        .ex_mem      (ex_mem.execute),
        .wb_rd       (wb_rd),
        .wb_write    (wb_write),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage i_memory_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .hold            (mem_busy),
        .ex_mem          (ex_mem.memory),
        .mem_address     (mem_address),
        .mem_write_data  (mem_write_data),
        .mem_byte_enable (mem_byte_enable),
        .mem_write       (mem_write),
        .mem_read        (mem_read),
        .mem_read_data   (mem_read_data),
        .wb_rd           (wb_rd),
        .wb_write        (wb_write),
        .wb_data         (wb_data)
    );

endmodule

`default_nettype wire

/* sim/backend_properties.sv */
`default_nettype none

module backend_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        mem_write,
    input logic        mem_read,
    input logic        mem_busy,
    input logic        stall,
    input logic        redirect,
    input logic [31:0] mem_address,
    input logic [31:0] mem_write_data,
    input logic [3:0]  mem_byte_enable
);
    timeunit 1ns;
    timeprecision 1ns;

    int failures = 0;

    // A write held by busy keeps its address, data and lanes
    write_held_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_write && mem_busy) |=> (mem_write && $stable(mem_address)
            && $stable(mem_write_data) && $stable(mem_byte_enable))
    ) else begin
        $error("store changed while memory busy");
        failures++;
    end

    // Quiet outputs in reset and on the first edge after it
    idle_in_reset: assert property (
        @(posedge clk) (!rst_n || $rose(rst_n))
        |-> (!mem_write && !mem_read && !redirect && !stall)
    ) else begin
        $error("control output active during reset");
        failures++;
    end

    // Redirect squashes decode, so the next cycle has no jump in execute
    redirect_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (redirect && !mem_busy) |=> !redirect
    ) else begin
        $error("redirect still high after an unheld cycle");
        failures++;
    end

endmodule

bind backend backend_properties i_backend_properties (.*);

`default_nettype wire

/* sim/backend_tb.sv */
`default_nettype none

module backend_tb;
    timeunit 1ns;
    timeprecision 1ns;

    logic        clk;
    logic        rst_n;
    logic        instruction_valid;
    logic [31:0] pc_in;
    logic [31:0] instruction;
    logic [31:0] mem_address;
    logic [31:0] mem_write_data;
    logic [3:0]  mem_byte_enable;
    logic        mem_write;
    logic        mem_read;
    logic [31:0] mem_read_data;
    logic        mem_busy;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;

    logic [31:0] tdata [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] fe_pc;
    logic [31:0] next_pc;
    logic [31:0] lane_mask;
    integer      seed;
    int          prog_words;
    int          store_count;
    int          stores_seen;
    int          errors;
    int          assertion_failures;
    int          rec;

    backend i_backend (
        .clk               (clk),
        .rst_n             (rst_n),
        .instruction_valid (instruction_valid),
        .pc_in             (pc_in),
        .instruction       (instruction),
        .mem_address       (mem_address),
        .mem_write_data    (mem_write_data),
        .mem_byte_enable   (mem_byte_enable),
        .mem_write         (mem_write),
        .mem_read          (mem_read),
        .mem_read_data     (mem_read_data),
        .mem_busy          (mem_busy),
        .stall             (stall),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] tword(int i);
        return tdata[8'(i)];
    endfunction

    function automatic logic in_program(logic [31:0] pc);
        return int'(pc[31:2]) < prog_words;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_idle(string phase);
        check_value({phase, " mem_write"}, 32'h0, {31'b0, mem_write});
        check_value({phase, " mem_read"}, 32'h0, {31'b0, mem_read});
        check_value({phase, " redirect"}, 32'h0, {31'b0, redirect});
        check_value({phase, " stall"}, 32'h0, {31'b0, stall});
    endtask

    // ==================================================
    // Front end and data memory models
    // ==================================================
    // Predict not taken, hold on stall, follow redirects
    always @(posedge clk) begin
        next_pc = fe_pc;
        if (!rst_n)
            next_pc = '0;
        else if (redirect)
            next_pc = redirect_pc;
        else if (instruction_valid && !stall)
            next_pc = fe_pc + 32'd4;
        fe_pc             <= next_pc;
        pc_in             <= next_pc;
        instruction       <= in_program(next_pc) ? tword(1 + int'(next_pc[31:2])) : '0;
        instruction_valid <= rst_n && in_program(next_pc);
    end

    // Busy about one cycle in four
    always @(posedge clk) begin
        if (!rst_n)
            mem_busy <= 1'b0;
        else
            mem_busy <= ($random(seed) & 32'sd3) == 32'sd0;
    end

    // Read data only while a load is on the port
    assign mem_read_data = mem_read ? dmem[mem_address[9:2]] : '0;
    assign lane_mask     = {{8{mem_byte_enable[3]}}, {8{mem_byte_enable[2]}},
                            {8{mem_byte_enable[1]}}, {8{mem_byte_enable[0]}}};

    // Completed stores are compared in order with the records
    always @(posedge clk) begin
        if (rst_n && mem_write && !mem_busy) begin
            dmem[mem_address[9:2]] <= (dmem[mem_address[9:2]] & ~lane_mask)
                                      | (mem_write_data & lane_mask);
            if (stores_seen < store_count) begin
                rec = 2 + prog_words + 3 * stores_seen;
                check_value($sformatf("store %0d address", stores_seen), tword(rec),
                            mem_address);
                check_value($sformatf("store %0d data", stores_seen), tword(rec + 1),
                            mem_write_data);
                check_value($sformatf("store %0d byte enable", stores_seen),
                            tword(rec + 2), {28'b0, mem_byte_enable});
            end else begin
                $display("Unexpected extra store to address %h", mem_address);
                errors++;
            end
            stores_seen++;
        end
    end

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        errors            = 0;
        stores_seen       = 0;
        seed              = 75;
        rst_n             = 1'b0;
        instruction_valid = 1'b0;
        pc_in             = '0;
        instruction       = '0;
        mem_busy          = 1'b0;
        fe_pc             = '0;
        for (int i = 0; i < 256; i++)
            dmem[8'(i)] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
        $readmemh("sim/backend_testdata.txt", tdata);
        prog_words  = int'(tdata[0]);
        store_count = int'(tword(1 + prog_words));

        repeat (10) begin
            @(negedge clk);
            check_idle("reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        wait (stores_seen >= store_count);
        // Room for any store that should not happen
        repeat (20) @(posedge clk);
        check_value("store count", 32'(store_count), 32'(stores_seen));

        assertion_failures = i_backend.i_backend_properties.failures;
        $display("Errors: %0d, assertion failures %0d, stores seen %0d of %0d",
                 errors, assertion_failures, stores_seen, store_count);
        if (errors == 0 && assertion_failures == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #1;
        repeat (10 + 40 * prog_words) @(posedge clk);
        $display("Timeout: only %0d of %0d stores completed", stores_seen, store_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/backend_pkg.sv
source/stage_if.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/backend.sv
sim/backend_properties.sv
sim/backend_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = backend_tb
FILELIST  = all.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@output="$$(./obj_dir/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

/* sim/backend_testdata.txt */
// Program word count, program words from address 0, expected store count
// Each store record: address data byte_enable
27
00500093 00708113 401101B3 10302023 00411213 FFF24293 10502223 10002303
002303B3 10702423 104006A3 10401923 10D00403 10D04483 10802A23 10902C23
00208463 00209463 10102E23 00C0056F 10202E23 10202E23 10A02E23 07000593
00458667 12102023 12102023 12102023 12102023 12C02023 0002C463 12102223
0002F463 12102223 123456B7 00001717 00E687B3 12F02223 12D02423
0B
00000100 00000007 F
00000104 FFFFFF3F F
00000108 00000013 F
0000010D C0C0C0C0 2
00000112 00C000C0 C
00000114 FFFFFFC0 F
00000118 000000C0 F
0000011C 00000050 F
00000120 00000064 F
00000124 1234608C F
00000128 12345000 F
